// File: hw/ciu_regs_pkg.sv
// Shared widths, indexes and field layouts; data is fixed at 64 bits and at most four requesters
package ciu_regs_pkg;

  //==========================================================================
  // Widths
  //==========================================================================
  localparam int DATA_W      = 64;
  localparam int NUM_REQ_MAX = 4;
  localparam int IPRF_W      = 2;
  localparam int LTNCY_W     = 3;

  // CSR update operations where code 3 writes zero
  typedef enum logic [1:0] {
    CSR_RW = 2'd0,
    CSR_RS = 2'd1,
    CSR_RC = 2'd2
  } csr_op_e;

  // Shared register indexes
  typedef enum logic [3:0] {
    IDX_CCR2  = 4'd0,
    IDX_HINT2 = 4'd1,
    IDX_CER2  = 4'd2,
    IDX_EIR2  = 4'd3
  } reg_idx_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'b00,
    ST_READ  = 2'b01,
    ST_WRITE = 2'b10
  } fsm_state_e;

  // One register operation from a requester
  typedef struct packed {
    logic                write;
    csr_op_e             csr_op;
    reg_idx_e            idx;
    logic [DATA_W-1:0]   wdata;
  } reg_req_t;

  //==========================================================================
  // CCR2 layout
  //==========================================================================
  typedef struct packed {
    logic               tprf;
    logic [IPRF_W-1:0]  iprf;
    logic               tsetup;
    logic [LTNCY_W-1:0] tltncy;
    logic               dsetup;
    logic [LTNCY_W-1:0] dltncy;
  } l2_ram_cfg_t;

  localparam int CCR2_TPRF_BIT   = 31;
  localparam int CCR2_IPRF_LSB   = 29;
  localparam int CCR2_TSETUP_BIT = 25;
  localparam int CCR2_TLTNCY_LSB = 22;
  localparam int CCR2_DSETUP_BIT = 19;
  localparam int CCR2_DLTNCY_LSB = 16;
  // Constant ones for inclusive and L2 enable
  localparam int CCR2_L2E_BIT    = 3;
  localparam int CCR2_INCL_BIT   = 0;

  localparam logic [LTNCY_W-1:0] LTNCY_RST = 3'd1;

  localparam l2_ram_cfg_t CCR2_CFG_RST = '{
    tprf:   1'b0,
    iprf:   '0,
    tsetup: 1'b0,
    tltncy: LTNCY_RST,
    dsetup: 1'b0,
    dltncy: LTNCY_RST
  };

  //==========================================================================
  // CHR2 layout from bit 10 down to bit 0
  //==========================================================================
  typedef struct packed {
    logic       so_ostd_dis;
    logic       global_icg_en;
    logic       sysio_icg_en;
    logic       apbif_icg_en;
    logic       l2c_icg_en;
    logic       dvm_dis;
    logic       sf_dis;
    logic [1:0] rsvd;          // stored but drives nothing
    logic       ciu_icg_en;
    logic       bar_dis;
  } hint_cfg_t;

  localparam int HINT_W = $bits(hint_cfg_t);

endpackage

// File: hw/ciu_req_arbiter.sv
// Fixed priority where the highest index wins; the owner must hold sel until its cmplt
`timescale 1ns/10ps
module ciu_req_arbiter #(
  parameter int NUM_REQ = ciu_regs_pkg::NUM_REQ_MAX
) (
  input  logic                   ccr2_clk,
  input  logic                   cpurst_b,
  input  logic [NUM_REQ-1:0]     sel,
  input  ciu_regs_pkg::reg_req_t req [NUM_REQ],
  input  logic                   accept,
  output logic [NUM_REQ-1:0]     grant,
  output ciu_regs_pkg::reg_req_t cur_req,
  output logic                   req_vld
);

  logic [NUM_REQ-1:0] pri_grant;
  logic [NUM_REQ-1:0] grant_q;
  logic               owner_busy;

  // Later iterations override so the top active index wins
  always_comb
  begin
    pri_grant = '0;
    for (int i = 0; i < NUM_REQ; i++)
    begin
      if (sel[i])
      begin
        pri_grant    = '0;
        pri_grant[i] = 1'b1;
      end
    end
  end

  // Owner keeps sel high through its cmplt cycle
  assign owner_busy = |(grant_q & sel);
  assign grant      = owner_busy ? grant_q : pri_grant;
  assign req_vld    = |grant;

  // Grant captured on accept and dropped once the owner lets go of sel
  always_ff @(posedge ccr2_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      grant_q <= '0;
    else if (accept)
      grant_q <= grant;
    else if (!owner_busy)
      grant_q <= '0;
  end

  // Granted request onto the shared path
  always_comb
  begin
    cur_req = '0;
    for (int i = 0; i < NUM_REQ; i++)
    begin
      if (grant[i])
        cur_req = req[i];
    end
  end

endmodule

// File: hw/ciu_regs_fsm.sv
// One transaction at a time; reads finish in the read state and writes one cycle later
`timescale 1ns/10ps
module ciu_regs_fsm (
  input  logic ccr2_clk,
  input  logic cpurst_b,
  input  logic req_vld,
  input  logic write,
  output logic accept,
  output logic wen,
  output logic done
);

  ciu_regs_pkg::fsm_state_e cur_state;
  ciu_regs_pkg::fsm_state_e next_state;
  logic                     st_idle;
  logic                     st_read;
  logic                     st_write;

  //==========================================================================
  // State register
  //==========================================================================
  always_ff @(posedge ccr2_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= ciu_regs_pkg::ST_IDLE;
    else
      cur_state <= next_state;
  end

  always_comb
  begin
    case (cur_state)
      ciu_regs_pkg::ST_IDLE:
      begin
        if (req_vld)
          next_state = ciu_regs_pkg::ST_READ;
        else
          next_state = ciu_regs_pkg::ST_IDLE;
      end
      ciu_regs_pkg::ST_READ:
      begin
        // Writes take one more cycle
        if (write)
          next_state = ciu_regs_pkg::ST_WRITE;
        else
          next_state = ciu_regs_pkg::ST_IDLE;
      end
      ciu_regs_pkg::ST_WRITE:
      begin
        next_state = ciu_regs_pkg::ST_IDLE;
      end
      default:
      begin
        next_state = ciu_regs_pkg::ST_IDLE;
      end
    endcase
  end

  //==========================================================================
  // Outputs
  //==========================================================================
  assign st_idle  = (cur_state == ciu_regs_pkg::ST_IDLE);
  assign st_read  = (cur_state == ciu_regs_pkg::ST_READ);
  assign st_write = (cur_state == ciu_regs_pkg::ST_WRITE);

  assign accept = st_idle & req_vld;
  // Register update lands on the edge that ends the read cycle
  assign wen    = st_read & write;
  assign done   = write ? st_write : st_read;

endmodule

// File: hw/ciu_l2_cfg_regs.sv
// Only CCR2 and CHR2 hold state; CER2, EIR2 and unknown indexes read zero and drop writes
`timescale 1ns/10ps
module ciu_l2_cfg_regs (
  input  logic                              ccr2_clk,
  input  logic                              cpurst_b,
  input  ciu_regs_pkg::reg_req_t            cur_req,
  input  logic                              accept,
  input  logic                              wen,
  output logic [ciu_regs_pkg::DATA_W-1:0]   rdata,
  output ciu_regs_pkg::l2_ram_cfg_t         ram_cfg,
  output ciu_regs_pkg::hint_cfg_t           hint_cfg
);

  logic [ciu_regs_pkg::DATA_W-1:0] ccr2_img;
  logic [ciu_regs_pkg::DATA_W-1:0] chr2_img;
  logic [ciu_regs_pkg::DATA_W-1:0] reg_dout;
  logic [ciu_regs_pkg::DATA_W-1:0] rdata_q;
  logic [ciu_regs_pkg::DATA_W-1:0] wdata_final;
  ciu_regs_pkg::l2_ram_cfg_t       ccr2_q;
  ciu_regs_pkg::hint_cfg_t         chr2_q;
  logic                            ccr2_wen;
  logic                            chr2_wen;

  //==========================================================================
  // Read images and index mux
  //==========================================================================
  always_comb
  begin
    ccr2_img                                = '0;
    ccr2_img[ciu_regs_pkg::CCR2_INCL_BIT]   = 1'b1;
    ccr2_img[ciu_regs_pkg::CCR2_L2E_BIT]    = 1'b1;
    ccr2_img[ciu_regs_pkg::CCR2_TPRF_BIT]   = ccr2_q.tprf;
    ccr2_img[ciu_regs_pkg::CCR2_IPRF_LSB +: ciu_regs_pkg::IPRF_W]    = ccr2_q.iprf;
    ccr2_img[ciu_regs_pkg::CCR2_TSETUP_BIT] = ccr2_q.tsetup;
    ccr2_img[ciu_regs_pkg::CCR2_TLTNCY_LSB +: ciu_regs_pkg::LTNCY_W] = ccr2_q.tltncy;
    ccr2_img[ciu_regs_pkg::CCR2_DSETUP_BIT] = ccr2_q.dsetup;
    ccr2_img[ciu_regs_pkg::CCR2_DLTNCY_LSB +: ciu_regs_pkg::LTNCY_W] = ccr2_q.dltncy;
  end

  assign chr2_img = {{(ciu_regs_pkg::DATA_W - ciu_regs_pkg::HINT_W){1'b0}}, chr2_q};

  always_comb
  begin
    case (cur_req.idx)
      ciu_regs_pkg::IDX_CCR2:  reg_dout = ccr2_img;
      ciu_regs_pkg::IDX_HINT2: reg_dout = chr2_img;
      // CER2 and EIR2 have no error sources behind them
      default:                 reg_dout = '0;
    endcase
  end

  // Old value captured at acceptance
  always_ff @(posedge ccr2_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rdata_q <= '0;
    else if (accept)
      rdata_q <= reg_dout;
  end

  assign rdata = rdata_q;

  //==========================================================================
  // Read-modify-write
  //==========================================================================
  always_comb
  begin
    case (cur_req.csr_op)
      ciu_regs_pkg::CSR_RW: wdata_final = cur_req.wdata;
      ciu_regs_pkg::CSR_RS: wdata_final = rdata_q | cur_req.wdata;
      ciu_regs_pkg::CSR_RC: wdata_final = rdata_q & ~cur_req.wdata;
      default:              wdata_final = '0;
    endcase
  end

  assign ccr2_wen = wen & (cur_req.idx == ciu_regs_pkg::IDX_CCR2);
  assign chr2_wen = wen & (cur_req.idx == ciu_regs_pkg::IDX_HINT2);

  // CCR2 fields without the reserved bits
  always_ff @(posedge ccr2_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ccr2_q <= ciu_regs_pkg::CCR2_CFG_RST;
    else if (ccr2_wen)
    begin
      ccr2_q.tprf   <= wdata_final[ciu_regs_pkg::CCR2_TPRF_BIT];
      ccr2_q.iprf   <= wdata_final[ciu_regs_pkg::CCR2_IPRF_LSB +: ciu_regs_pkg::IPRF_W];
      ccr2_q.tsetup <= wdata_final[ciu_regs_pkg::CCR2_TSETUP_BIT];
      ccr2_q.tltncy <= wdata_final[ciu_regs_pkg::CCR2_TLTNCY_LSB +: ciu_regs_pkg::LTNCY_W];
      ccr2_q.dsetup <= wdata_final[ciu_regs_pkg::CCR2_DSETUP_BIT];
      ccr2_q.dltncy <= wdata_final[ciu_regs_pkg::CCR2_DLTNCY_LSB +: ciu_regs_pkg::LTNCY_W];
    end
  end

  // CHR2 keeps the low eleven bits
  always_ff @(posedge ccr2_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      chr2_q <= '0;
    else if (chr2_wen)
      chr2_q <= ciu_regs_pkg::hint_cfg_t'(wdata_final[ciu_regs_pkg::HINT_W-1:0]);
  end

  assign ram_cfg  = ccr2_q;
  assign hint_cfg = chr2_q;

endmodule

// File: hw/ciu_regs_top.sv
// NUM_REQ is 1 to 4; single clock domain; requesters hold sel and req stable until their cmplt
`timescale 1ns/10ps
module ciu_regs_top #(
  parameter int NUM_REQ = ciu_regs_pkg::NUM_REQ_MAX
) (
  input  logic                            ccr2_clk,
  input  logic                            cpurst_b,
  input  logic [NUM_REQ-1:0]              sel,
  input  ciu_regs_pkg::reg_req_t          req [NUM_REQ],
  output logic [NUM_REQ-1:0]              cmplt,
  output logic [ciu_regs_pkg::DATA_W-1:0] rdata,
  output ciu_regs_pkg::l2_ram_cfg_t       ram_cfg,
  output ciu_regs_pkg::hint_cfg_t         hint_cfg,
  output logic                            l2c_rst_req
);

  logic [NUM_REQ-1:0]     grant;
  ciu_regs_pkg::reg_req_t cur_req;
  logic                   req_vld;
  logic                   accept;
  logic                   wen;
  logic                   done;

  //==========================================================================
  // Request arbitration
  //==========================================================================
  ciu_req_arbiter #(
    .NUM_REQ (NUM_REQ)
  ) i_arbiter (
    .ccr2_clk (ccr2_clk),
    .cpurst_b (cpurst_b),
    .sel      (sel),
    .req      (req),
    .accept   (accept),
    .grant    (grant),
    .cur_req  (cur_req),
    .req_vld  (req_vld)
  );

  //==========================================================================
  // Controller and register storage
  //==========================================================================
  ciu_regs_fsm i_fsm (
    .ccr2_clk (ccr2_clk),
    .cpurst_b (cpurst_b),
    .req_vld  (req_vld),
    .write    (cur_req.write),
    .accept   (accept),
    .wen      (wen),
    .done     (done)
  );

  ciu_l2_cfg_regs i_cfg_regs (
    .ccr2_clk (ccr2_clk),
    .cpurst_b (cpurst_b),
    .cur_req  (cur_req),
    .accept   (accept),
    .wen      (wen),
    .rdata    (rdata),
    .ram_cfg  (ram_cfg),
    .hint_cfg (hint_cfg)
  );

  // Only the owner of the grant sees completion
  assign cmplt = grant & {NUM_REQ{done}};

  // L2 reset request is high through reset and low after the first edge
  always_ff @(posedge ccr2_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      l2c_rst_req <= 1'b1;
    else
      l2c_rst_req <= 1'b0;
  end

endmodule

// File: bench/ciu_regs_properties.sv
// Bound into ciu_regs_top; latency rules assume a requester keeps sel up until its cmplt
`timescale 1ns/10ps
module ciu_regs_properties #(
  parameter int NUM_REQ = ciu_regs_pkg::NUM_REQ_MAX
) (
  input logic                   ccr2_clk,
  input logic                   cpurst_b,
  input logic [NUM_REQ-1:0]     sel,
  input logic [NUM_REQ-1:0]     cmplt,
  input logic                   accept,
  input ciu_regs_pkg::reg_req_t cur_req
);

  // At most one requester completes per cycle
  a_cmplt_onehot: assert property (@(posedge ccr2_clk) disable iff (!cpurst_b)
    $onehot0(cmplt))
    else $error("cmplt has more than one bit set");

  a_cmplt_sel: assert property (@(posedge ccr2_clk) disable iff (!cpurst_b)
    (cmplt & ~sel) == '0)
    else $error("cmplt raised for a requester without sel");

  //==========================================================================
  // Completion latency
  //==========================================================================
  a_read_lat: assert property (@(posedge ccr2_clk) disable iff (!cpurst_b)
    $past(accept && !cur_req.write) |-> (cmplt != '0))
    else $error("read did not complete one cycle after acceptance");

  a_write_gap: assert property (@(posedge ccr2_clk) disable iff (!cpurst_b)
    $past(accept && cur_req.write) |-> (cmplt == '0))
    else $error("write completed one cycle after acceptance");

  a_write_lat: assert property (@(posedge ccr2_clk) disable iff (!cpurst_b)
    $past(accept && cur_req.write, 2) |-> (cmplt != '0))
    else $error("write did not complete two cycles after acceptance");

endmodule

// File: bench/ciu_regs_tb.sv
// Runs from the project root so bench/ciu_regs_tests.txt resolves; NUM_REQ is fixed at 4 here
`timescale 1ns/10ps
module ciu_regs_tb;

  localparam int NUM_REQ   = 4;
  localparam int FIELDS    = 8;
  localparam int MAX_LINES = 32;

  logic                            ccr2_clk;
  logic                            cpurst_b;
  logic [NUM_REQ-1:0]              sel;
  ciu_regs_pkg::reg_req_t          req [NUM_REQ];
  logic [NUM_REQ-1:0]              cmplt;
  logic [ciu_regs_pkg::DATA_W-1:0] rdata;
  ciu_regs_pkg::l2_ram_cfg_t       ram_cfg;
  ciu_regs_pkg::hint_cfg_t         hint_cfg;
  logic                            l2c_rst_req;

  // Eight hex fields per test line
  logic [63:0] test_mem [FIELDS*MAX_LINES];
  int          num_lines;
  int          cur_line;
  int          cycle_cnt;
  int          cycle_limit;
  logic [31:0] lcg_state;

  ciu_regs_top #(
    .NUM_REQ (NUM_REQ)
  ) i_dut (
    .ccr2_clk    (ccr2_clk),
    .cpurst_b    (cpurst_b),
    .sel         (sel),
    .req         (req),
    .cmplt       (cmplt),
    .rdata       (rdata),
    .ram_cfg     (ram_cfg),
    .hint_cfg    (hint_cfg),
    .l2c_rst_req (l2c_rst_req)
  );

  bind ciu_regs_top ciu_regs_properties #(.NUM_REQ (NUM_REQ)) i_props (
    .ccr2_clk (ccr2_clk),
    .cpurst_b (cpurst_b),
    .sel      (sel),
    .cmplt    (cmplt),
    .accept   (accept),
    .cur_req  (cur_req)
  );

  initial
  begin
    ccr2_clk = 1'b0;
    forever #5 ccr2_clk = ~ccr2_clk;
  end

  always @(posedge ccr2_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
    begin
      $display("Timeout: no completion seen within %0d cycles", cycle_limit);
      $display("Testbench failed");
      $fatal(1, "cycle budget exceeded");
    end
  end

  //==========================================================================
  // Helpers
  //==========================================================================
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Highest set bit owns the line
  function automatic int top_bit(input logic [NUM_REQ-1:0] mask);
    int r;
    r = -1;
    for (int i = 0; i < NUM_REQ; i++)
      if (mask[i])
        r = i;
    return r;
  endfunction

  function automatic ciu_regs_pkg::reg_req_t line_req(input int k);
    ciu_regs_pkg::reg_req_t r;
    r.write  = test_mem[k*FIELDS+1][0];
    r.csr_op = ciu_regs_pkg::csr_op_e'(test_mem[k*FIELDS+2][1:0]);
    r.idx    = ciu_regs_pkg::reg_idx_e'(test_mem[k*FIELDS+3][3:0]);
    r.wdata  = test_mem[k*FIELDS+4];
    return r;
  endfunction

  // Noise on requesters that are not raised
  task automatic scramble_idle();
    for (int r = 0; r < NUM_REQ; r++)
    begin
      if (!sel[r])
      begin
        lcg_state           = lcg_step(lcg_state);
        req[r].wdata[63:32] = lcg_state;
        lcg_state           = lcg_step(lcg_state);
        req[r].wdata[31:0]  = lcg_state;
      end
    end
  endtask

  // New requesters take the first later line they own
  task automatic raise_requesters(input int k);
    logic [NUM_REQ-1:0] mask;
    mask = test_mem[k*FIELDS][NUM_REQ-1:0];
    for (int r = 0; r < NUM_REQ; r++)
    begin
      if (mask[r] && !sel[r])
      begin
        for (int j = num_lines - 1; j >= k; j--)
          if (top_bit(test_mem[j*FIELDS][NUM_REQ-1:0]) == r)
            req[r] = line_req(j);
        sel[r] = 1'b1;
      end
    end
  endtask

  task automatic report_mismatch(input string what);
    $display("[ERROR] %0t: %s", $time, what);
    $display("Testbench failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_rdata(input logic [ciu_regs_pkg::DATA_W-1:0] got,
                             input logic [ciu_regs_pkg::DATA_W-1:0] exp, input string ctx);
    if (got !== exp)
      report_mismatch($sformatf("%s: rdata %h, expected %h", ctx, got, exp));
  endtask

  task automatic check_ram_cfg(input ciu_regs_pkg::l2_ram_cfg_t got,
                               input ciu_regs_pkg::l2_ram_cfg_t exp, input string ctx);
    if (got !== exp)
      report_mismatch($sformatf("%s: ram_cfg %h, expected %h", ctx, got, exp));
  endtask

  task automatic check_hint_cfg(input ciu_regs_pkg::hint_cfg_t got,
                                input ciu_regs_pkg::hint_cfg_t exp, input string ctx);
    if (got !== exp)
      report_mismatch($sformatf("%s: hint_cfg %h, expected %h", ctx, got, exp));
  endtask

  task automatic check_cmplt(input logic [NUM_REQ-1:0] got, input logic [NUM_REQ-1:0] exp,
                             input string ctx);
    if (got !== exp)
      report_mismatch($sformatf("%s: cmplt %b, expected %b", ctx, got, exp));
  endtask

  task automatic check_rst_req(input logic got, input logic exp, input string ctx);
    if (got !== exp)
      report_mismatch($sformatf("%s: l2c_rst_req %b, expected %b", ctx, got, exp));
  endtask

  //==========================================================================
  // Main sequence
  //==========================================================================
  initial
  begin
    int                 owner;
    int                 base;
    string              ctx;
    logic [NUM_REQ-1:0] exp_cmplt;
    cpurst_b  = 1'b0;
    sel       = '0;
    lcg_state = 32'd90;
    foreach (req[r])
      req[r] = '0;
    foreach (test_mem[i])
      test_mem[i] = '0;
    $readmemh("bench/ciu_regs_tests.txt", test_mem);
    num_lines = 0;
    while (num_lines < MAX_LINES && test_mem[num_lines*FIELDS] != '0)
      num_lines++;
    cycle_limit = num_lines * 8 + 20;

    repeat (3) @(posedge ccr2_clk);
    #1;
    check_rst_req(l2c_rst_req, 1'b1, "in reset");
    cpurst_b = 1'b1;
    @(negedge ccr2_clk);
    check_rst_req(l2c_rst_req, 1'b1, "before first edge");
    @(negedge ccr2_clk);
    check_rst_req(l2c_rst_req, 1'b0, "after first edge");
    check_rdata(rdata, '0, "after reset");
    @(posedge ccr2_clk);
    #1;

    for (cur_line = 0; cur_line < num_lines; cur_line++)
    begin
      base  = cur_line * FIELDS;
      ctx   = $sformatf("test line %0d", cur_line + 1);
      owner = top_bit(test_mem[base][NUM_REQ-1:0]);
      scramble_idle();
      raise_requesters(cur_line);
      do
        @(negedge ccr2_clk);
      while (cmplt == '0);
      exp_cmplt        = '0;
      exp_cmplt[owner] = 1'b1;
      check_cmplt(cmplt, exp_cmplt, ctx);
      check_rdata(rdata, test_mem[base+5], ctx);
      check_ram_cfg(ram_cfg, ciu_regs_pkg::l2_ram_cfg_t'(test_mem[base+6][10:0]), ctx);
      check_hint_cfg(hint_cfg, ciu_regs_pkg::hint_cfg_t'(test_mem[base+7][10:0]), ctx);
      @(posedge ccr2_clk);
      #1;
      sel[owner] = 1'b0;
      @(posedge ccr2_clk);
      #1;
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: bench/ciu_regs_tests.txt
// mask write csr_op idx wdata exp_rdata exp_ram_cfg exp_hint_cfg, all hex, one transaction per line
// A multi-bit mask raises its requesters together; the highest set bit owns the line
1 0 0 0 0000000000000000 0000000000410009 011 000
2 1 0 0 DEADBEEFDD7BF0F6 0000000000410009 65B 000
4 0 0 0 0000000000000000 00000000C14B0009 65B 000
8 1 1 1 FFFF000000000255 0000000000000000 65B 255
1 1 1 1 0000000000000108 0000000000000255 65B 35D
2 1 2 1 0000000000000054 000000000000035D 65B 309
4 0 0 1 0000000000000000 0000000000000309 65B 309
8 0 0 2 0000000000000000 0000000000000000 65B 309
1 1 0 2 FFFFFFFFFFFFFFFF 0000000000000000 65B 309
2 0 0 3 0000000000000000 0000000000000000 65B 309
8 1 2 3 FFFFFFFFFFFFFFFF 0000000000000000 65B 309
4 1 1 7 FFFFFFFFFFFFFFFF 0000000000000000 65B 309
8 0 0 F 0000000000000000 0000000000000000 65B 309
1 1 3 1 0000000000000FFF 0000000000000309 65B 000
F 1 0 1 00000000000007FF 0000000000000000 65B 7FF
7 1 2 1 00000000000000F0 00000000000007FF 65B 70F
3 0 0 1 0000000000000000 000000000000070F 65B 70F
1 1 0 0 0000000000000000 00000000C14B0009 000 70F
4 0 0 0 0000000000000000 0000000000000009 000 70F

// File: verilog.f
hw/ciu_regs_pkg.sv
hw/ciu_req_arbiter.sv
hw/ciu_regs_fsm.sv
hw/ciu_l2_cfg_regs.sv
hw/ciu_regs_top.sv
bench/ciu_regs_properties.sv
bench/ciu_regs_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module ciu_regs_tb -f verilog.f > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vciu_regs_tb > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "Testbench failed" sim.log && { echo "Simulation FAILED"; exit 1; } || true
grep -q "Testbench passed" sim.log && echo "Simulation PASSED" || { echo "No verdict"; exit 1; }
